// ==== design/ps2_defs.svh ====
// PS/2 receiver constants for frame format, special scan codes and watchdog length
`ifndef PS2_DEFS_SVH
`define PS2_DEFS_SVH

// Start bit, 8 data bits, parity and stop bit
`define PS2_FRAME_BITS      11

// Scan codes handled outside the ASCII table
`define PS2_RELEASE_CODE    8'hf0
`define PS2_LEFT_SHIFT      8'h12
`define PS2_RIGHT_SHIFT     8'h59

// Idle clock high time that aborts a frame, about 60 us at 50 MHz
`define PS2_WATCHDOG_CYCLES 2950
`define PS2_WATCHDOG_BITS   12

// Full stop for keys without a table entry
`define PS2_UNMAPPED_ASCII  8'h2e

`endif

// ==== design/ps2_pkg.sv ====
// Shared types for the PS/2 keyboard receiver
package ps2_pkg;

  typedef logic [7:0] scan_code_t;  // One byte from the keyboard
  typedef logic [7:0] ascii_t;      // Translated character

  // Synchronized levels of the two keyboard lines
  typedef struct packed {
    logic clk;   // Keyboard clock level
    logic data;  // Keyboard data level
  } ps2_line_t;

  // One decoded key as seen by the host
  typedef struct packed {
    logic       released;  // Code followed an F0 prefix
    scan_code_t code;      // Raw scan code
    ascii_t     ascii;     // Character with shift applied
  } ps2_key_event_t;

endpackage

// ==== design/ps2_rx_fsm.sv ====
// PS/2 line synchronizer and receive FSM that marks keyboard clock edges
module ps2_rx_fsm
  import ps2_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      ps2_clk_i,
  input  logic      ps2_data_i,
  input  logic      expired_i,   // Watchdog ran out
  output ps2_line_t line_o,      // Registered line levels
  output logic      timer_en_o,
  output logic      shift_o,     // Take a bit on a falling edge
  output logic      abort_o      // Drop the partial frame
);

  typedef enum logic [1:0] {
    ST_CLK_H,
    ST_FALL_MARK,
    ST_CLK_L,
    ST_RISE_MARK
  } state_t;

  state_t state;
  state_t next_state;

  // Lines idle high, so reset to that level to avoid a false edge
  always_ff @(posedge clk)
  begin
    if (reset)
      line_o <= '1;
    else
      line_o <= '{clk: ps2_clk_i, data: ps2_data_i};
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ST_CLK_H;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      ST_CLK_H:
      begin
        if (!line_o.clk)
          next_state = ST_FALL_MARK;  // Keyboard pulled clock low
      end
      ST_FALL_MARK: next_state = ST_CLK_L;  // One cycle only
      ST_CLK_L:
      begin
        if (line_o.clk)
          next_state = ST_RISE_MARK;
      end
      ST_RISE_MARK: next_state = ST_CLK_H;
      default:      next_state = ST_CLK_H;
    endcase
  end

  // Watchdog runs only in the steady states
  assign timer_en_o = (state == ST_CLK_H) || (state == ST_CLK_L);
  assign shift_o    = (state == ST_FALL_MARK);
  assign abort_o    = (state == ST_CLK_H) && line_o.clk && expired_i;  // Stalled mid-frame

  // Watchdog restarts at every edge marker
  a_watchdog_restart: assert property (@(posedge clk) disable iff (reset)
    !timer_en_o |=> !expired_i);

endmodule

// ==== design/ps2_watchdog_timer.sv ====
// Watchdog counter that flags a PS/2 clock held steady too long
`include "ps2_defs.svh"

module ps2_watchdog_timer #(
  parameter int CYCLES = `PS2_WATCHDOG_CYCLES
) (
  input  logic clk,
  input  logic reset,
  input  logic enable_i,   // High in steady clock states
  output logic expired_o   // Level, held while enabled
);

  localparam logic [`PS2_WATCHDOG_BITS-1:0] LAST_COUNT = `PS2_WATCHDOG_BITS'(CYCLES - 1);

  logic [`PS2_WATCHDOG_BITS-1:0] count;

  // Restarts at every clock edge marker
  always_ff @(posedge clk)
  begin
    if (reset || !enable_i)
      count <= '0;
    else if (!expired_o)
      count <= count + 1'b1;  // Saturates at the last count
  end

  assign expired_o = (count == LAST_COUNT);

endmodule

// ==== design/ps2_frame_shifter.sv ====
// Shift register and bit counter assembling one 11-bit PS/2 frame
`include "ps2_defs.svh"

module ps2_frame_shifter
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  ps2_line_t  line_i,
  input  logic       shift_i,       // One pulse per falling edge
  input  logic       abort_i,       // Watchdog abort
  output logic       frame_done_o,  // One cycle at full count
  output scan_code_t code_o
);

  localparam int CNT_BITS = $clog2(`PS2_FRAME_BITS + 1);

  logic [`PS2_FRAME_BITS-1:0] frame_q;   // LSB first, so the start bit ends in bit 0
  logic [CNT_BITS-1:0]        bit_count;

  // Newest bit enters at the top
  always_ff @(posedge clk)
  begin
    if (shift_i)
      frame_q <= {line_i.data, frame_q[`PS2_FRAME_BITS-1:1]};
  end

  always_ff @(posedge clk)
  begin
    if (reset || frame_done_o || abort_i)
      bit_count <= '0;  // Ready for next start bit
    else if (shift_i)
      bit_count <= bit_count + 1'b1;
  end

  assign frame_done_o = (bit_count == CNT_BITS'(`PS2_FRAME_BITS));
  assign code_o       = frame_q[8:1];  // Skip start bit, drop parity and stop

  // Count must clear before another falling edge arrives
  a_count_range: assert property (@(posedge clk) disable iff (reset)
    shift_i |-> bit_count < CNT_BITS'(`PS2_FRAME_BITS));

endmodule

// ==== design/ps2_ascii_map.sv ====
// Scan code to ASCII lookup for letters, digits and a few control keys
`include "ps2_defs.svh"

module ps2_ascii_map
  import ps2_pkg::*;
(
  input  scan_code_t code_i,
  input  logic       shift_i,  // Either shift key held
  output ascii_t     ascii_o
);

  ascii_t base;       // Unshifted character
  logic   is_letter;

  always_comb
  begin
    case (code_i)
      8'h29:   base = 8'h20;  // Space
      8'h5a:   base = 8'h0d;  // Enter gives carriage return
      8'h66:   base = 8'h08;  // Backspace
      8'h76:   base = 8'h1b;  // Escape
      8'h45:   base = 8'h30;  // 0
      8'h16:   base = 8'h31;  // 1
      8'h1e:   base = 8'h32;  // 2
      8'h26:   base = 8'h33;  // 3
      8'h25:   base = 8'h34;  // 4
      8'h2e:   base = 8'h35;  // 5
      8'h36:   base = 8'h36;  // 6
      8'h3d:   base = 8'h37;  // 7
      8'h3e:   base = 8'h38;  // 8
      8'h46:   base = 8'h39;  // 9
      8'h1c:   base = 8'h61;  // a
      8'h32:   base = 8'h62;  // b
      8'h21:   base = 8'h63;  // c
      8'h23:   base = 8'h64;  // d
      8'h24:   base = 8'h65;  // e
      8'h2b:   base = 8'h66;  // f
      8'h34:   base = 8'h67;  // g
      8'h33:   base = 8'h68;  // h
      8'h43:   base = 8'h69;  // i
      8'h3b:   base = 8'h6a;  // j
      8'h42:   base = 8'h6b;  // k
      8'h4b:   base = 8'h6c;  // l
      8'h3a:   base = 8'h6d;  // m
      8'h31:   base = 8'h6e;  // n
      8'h44:   base = 8'h6f;  // o
      8'h4d:   base = 8'h70;  // p
      8'h15:   base = 8'h71;  // q
      8'h2d:   base = 8'h72;  // r
      8'h1b:   base = 8'h73;  // s
      8'h2c:   base = 8'h74;  // t
      8'h3c:   base = 8'h75;  // u
      8'h2a:   base = 8'h76;  // v
      8'h1d:   base = 8'h77;  // w
      8'h22:   base = 8'h78;  // x
      8'h35:   base = 8'h79;  // y
      8'h1a:   base = 8'h7a;  // z
      default: base = `PS2_UNMAPPED_ASCII;
    endcase
  end

  // Only letters react to shift, digits stay as they are
  assign is_letter = (base >= 8'h61) && (base <= 8'h7a);

  // Upper case sits 0x20 below lower case
  assign ascii_o = (shift_i && is_letter) ? base - 8'h20 : base;

endmodule

// ==== design/ps2_key_tracker.sv ====
// Release prefix, shift key state and host output register with ready level
`include "ps2_defs.svh"

module ps2_key_tracker
  import ps2_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           frame_done_i,  // Full frame in the shifter
  input  scan_code_t     code_i,
  input  logic           read_i,        // Host acknowledge pulse
  output ps2_key_event_t key_o,
  output logic           shift_on_o,
  output logic           ready_o
);

  logic   is_release;      // F0 prefix just arrived
  logic   key_strobe;      // Any other code, produces output
  logic   release_pending;
  logic   left_shift;
  logic   right_shift;
  ascii_t ascii;

  assign is_release = frame_done_i && (code_i == `PS2_RELEASE_CODE);
  assign key_strobe = frame_done_i && !is_release;

  // Translation uses the shift state from before this frame
  ps2_ascii_map i_ascii_map (
    .code_i  (code_i),
    .shift_i (shift_on_o),
    .ascii_o (ascii)
  );

  always_ff @(posedge clk)
  begin
    if (reset || key_strobe)
      release_pending <= 1'b0;  // Consumed by the next key
    else if (is_release)
      release_pending <= 1'b1;
  end

  // Press sets, release clears
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift  <= 1'b0;
      right_shift <= 1'b0;
    end
    else if (key_strobe)
    begin
      if (code_i == `PS2_LEFT_SHIFT)
        left_shift <= !release_pending;
      if (code_i == `PS2_RIGHT_SHIFT)
        right_shift <= !release_pending;
    end
  end

  assign shift_on_o = left_shift || right_shift;

  // New key overwrites an unread one
  always_ff @(posedge clk)
  begin
    if (reset)
      key_o <= '0;
    else if (key_strobe)
      key_o <= '{released: release_pending, code: code_i, ascii: ascii};
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      ready_o <= 1'b0;
    else if (key_strobe)
      ready_o <= 1'b1;  // Wins over a read in the same cycle
    else if (read_i)
      ready_o <= 1'b0;
  end

  // Each frame is handed over once
  a_single_frame: assert property (@(posedge clk) disable iff (reset)
    frame_done_i |=> !frame_done_i);

endmodule

// ==== design/ps2_keyboard_rx.sv ====
// PS/2 keyboard receiver top level from line sampling to decoded key output
module ps2_keyboard_rx
  import ps2_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           ps2_clk_i,   // Asynchronous, idle high
  input  logic           ps2_data_i,  // Asynchronous, idle high
  input  logic           read_i,
  output ps2_key_event_t key_o,
  output logic           shift_on_o,
  output logic           ready_o
);

  ps2_line_t  line;
  logic       timer_en;
  logic       expired;
  logic       shift;
  logic       abort;
  logic       frame_done;
  scan_code_t code;

  ps2_rx_fsm i_rx_fsm (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk_i  (ps2_clk_i),
    .ps2_data_i (ps2_data_i),
    .expired_i  (expired),
    .line_o     (line),
    .timer_en_o (timer_en),
    .shift_o    (shift),
    .abort_o    (abort)
  );

  ps2_watchdog_timer i_watchdog_timer (
    .clk       (clk),
    .reset     (reset),
    .enable_i  (timer_en),
    .expired_o (expired)
  );

  ps2_frame_shifter i_frame_shifter (
    .clk          (clk),
    .reset        (reset),
    .line_i       (line),
    .shift_i      (shift),
    .abort_i      (abort),
    .frame_done_o (frame_done),
    .code_o       (code)
  );

  ps2_key_tracker i_key_tracker (
    .clk          (clk),
    .reset        (reset),
    .frame_done_i (frame_done),
    .code_i       (code),
    .read_i       (read_i),
    .key_o        (key_o),
    .shift_on_o   (shift_on_o),
    .ready_o      (ready_o)
  );

endmodule

// ==== verification/tb_ps2_keyboard_rx.sv ====
// Testbench for the PS/2 keyboard receiver with a keyboard model and checking assertions
`include "ps2_defs.svh"

module tb_ps2_keyboard_rx
  import ps2_pkg::*;
();

  localparam int NUM_FRAMES     = 19;  // Partial watchdog frame included
  localparam int MAX_HALF       = 30;  // Slowest keyboard half-period
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * 22 * MAX_HALF + 3 * `PS2_WATCHDOG_CYCLES;

  logic           clk = 1'b0;
  logic           reset;
  logic           ps2_clk;
  logic           ps2_data;
  logic           host_read;
  ps2_key_event_t key;
  logic           shift_on;
  logic           ready;

  // One-cycle check requests for the assertions
  logic           check_key_en;
  logic           check_shift_en;
  logic           check_ready_en;
  ps2_key_event_t exp_key;
  logic           exp_shift;
  logic           exp_ready;

  string test_name = "reset";
  int    error_count = 0;
  int    check_count = 0;
  int    test_count = 0;
  int    errors_at_start = 0;
  int    cycle_count = 0;

  always #4 clk = ~clk;  // 8 unit period

  ps2_keyboard_rx i_dut (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk_i  (ps2_clk),
    .ps2_data_i (ps2_data),
    .read_i     (host_read),
    .key_o      (key),
    .shift_on_o (shift_on),
    .ready_o    (ready)
  );

  // Hard stop if the receiver never answers
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout in %s, the receiver gave no response within %0d cycles",
               test_name, TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  a_key: assert property (@(posedge clk) check_key_en |-> key == exp_key)
  else
  begin
    $display("FAILED %s: key expected %h actual %h", test_name, $sampled(exp_key),
             $sampled(key));
    error_count++;
  end

  a_shift: assert property (@(posedge clk) check_shift_en |-> shift_on == exp_shift)
  else
  begin
    $display("FAILED %s: shift_on expected %b actual %b", test_name, $sampled(exp_shift),
             $sampled(shift_on));
    error_count++;
  end

  a_ready: assert property (@(posedge clk) check_ready_en |-> ready == exp_ready)
  else
  begin
    $display("FAILED %s: ready expected %b actual %b", test_name, $sampled(exp_ready),
             $sampled(ready));
    error_count++;
  end

  // Reference table for the codes sent here
  function automatic ascii_t expected_ascii(input scan_code_t code, input logic shifted);
    case (code)
      8'h1c:   expected_ascii = shifted ? 8'h41 : 8'h61;  // A or a
      8'h16:   expected_ascii = 8'h31;                    // Digit 1 ignores shift
      default: expected_ascii = 8'h2e;                    // Full stop
    endcase
  endfunction

  // Stop, odd parity, data LSB first, start
  function automatic logic [`PS2_FRAME_BITS-1:0] frame_bits(input scan_code_t code);
    frame_bits = {1'b1, ~^code, code, 1'b0};
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Keyboard model that moves data mid high phase
  task automatic send_bits(input logic [`PS2_FRAME_BITS-1:0] bits, input int count);
    int half;
    int i;
    half = 10 + int'($urandom % 21);  // 10 to 30 cycles
    for (i = 0; i < count; i++)
    begin
      ps2_data <= bits[i];
      wait_cycles(half / 2);
      ps2_clk <= 1'b0;  // Receiver samples here
      wait_cycles(half);
      ps2_clk <= 1'b1;
      wait_cycles(half - half / 2);
    end
  endtask

  task automatic send_frame(input scan_code_t code);
    send_bits(frame_bits(code), `PS2_FRAME_BITS);
  endtask

  task automatic wait_ready();
    while (!ready)
      @(posedge clk);
  endtask

  task automatic read_key();
    host_read <= 1'b1;
    @(posedge clk);
    host_read <= 1'b0;
  endtask

  task automatic receive_key(input scan_code_t code);
    send_frame(code);
    wait_ready();
    read_key();
  endtask

  task automatic release_key(input scan_code_t code);
    send_frame(`PS2_RELEASE_CODE);
    receive_key(code);
  endtask

  task automatic expect_key(input logic rel, input scan_code_t code, input logic shifted);
    exp_key      <= '{released: rel, code: code, ascii: expected_ascii(code, shifted)};
    check_key_en <= 1'b1;
    check_count++;
    @(posedge clk);
    check_key_en <= 1'b0;
  endtask

  task automatic expect_shift(input logic value);
    exp_shift      <= value;
    check_shift_en <= 1'b1;
    check_count++;
    @(posedge clk);
    check_shift_en <= 1'b0;
  endtask

  task automatic expect_ready(input logic value);
    exp_ready      <= value;
    check_ready_en <= 1'b1;
    check_count++;
    @(posedge clk);
    check_ready_en <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  task automatic finish_test();
    @(posedge clk);  // Last assertion reports on this edge
    test_count++;
    $display("%-16s %s, %0d error(s)", test_name,
             (error_count == errors_at_start) ? "pass" : "fail", error_count - errors_at_start);
  endtask

  initial
  begin
    reset          <= 1'b1;
    ps2_clk        <= 1'b1;  // Lines idle high
    ps2_data       <= 1'b1;
    host_read      <= 1'b0;
    check_key_en   <= 1'b0;
    check_shift_en <= 1'b0;
    check_ready_en <= 1'b0;
    exp_key        <= '0;
    exp_shift      <= 1'b0;
    exp_ready      <= 1'b0;
    void'($urandom(32'h7e26_ee6d));
    wait_cycles(8);
    reset <= 1'b0;
    wait_cycles(4);

    start_test("key_press");
    send_frame(8'h1c);
    wait_ready();
    expect_key(1'b0, 8'h1c, 1'b0);
    wait_cycles(20);  // Ready holds with no read
    expect_ready(1'b1);
    read_key();
    expect_ready(1'b0);
    finish_test();

    start_test("release");
    send_frame(`PS2_RELEASE_CODE);
    wait_cycles(10);
    expect_ready(1'b0);  // Prefix alone is silent
    receive_key(8'h1c);
    expect_key(1'b1, 8'h1c, 1'b0);
    finish_test();

    start_test("shift");
    receive_key(`PS2_LEFT_SHIFT);
    expect_shift(1'b1);
    receive_key(8'h1c);
    expect_key(1'b0, 8'h1c, 1'b1);
    release_key(`PS2_LEFT_SHIFT);
    expect_shift(1'b0);
    receive_key(`PS2_RIGHT_SHIFT);
    expect_shift(1'b1);
    receive_key(8'h1c);
    expect_key(1'b0, 8'h1c, 1'b1);
    release_key(`PS2_RIGHT_SHIFT);
    expect_shift(1'b0);
    finish_test();

    start_test("unmapped_digit");
    receive_key(8'h0e);
    expect_key(1'b0, 8'h0e, 1'b0);
    receive_key(8'h16);
    expect_key(1'b0, 8'h16, 1'b0);
    receive_key(`PS2_LEFT_SHIFT);
    expect_shift(1'b1);
    receive_key(8'h16);  // Digit with shift held
    expect_key(1'b0, 8'h16, 1'b1);
    release_key(`PS2_LEFT_SHIFT);
    expect_shift(1'b0);
    finish_test();

    start_test("watchdog");
    send_bits(frame_bits(8'h1c), 4);  // Keyboard stalls mid frame
    ps2_data <= 1'b1;
    wait_cycles(`PS2_WATCHDOG_CYCLES + 100);
    expect_ready(1'b0);
    receive_key(8'h1c);  // Decodes only if the stale bits were dropped
    expect_key(1'b0, 8'h1c, 1'b0);
    finish_test();

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+design
design/ps2_pkg.sv
design/ps2_rx_fsm.sv
design/ps2_watchdog_timer.sv
design/ps2_frame_shifter.sv
design/ps2_ascii_map.sv
design/ps2_key_tracker.sv
design/ps2_keyboard_rx.sv
verification/tb_ps2_keyboard_rx.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_ps2_keyboard_rx -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
